//--- list.f
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/dispatch_ifs.sv
verilog/op_classify.sv
verilog/reg_rename.sv
verilog/dispatch_steer.sv
verilog/dispatch_top.sv
tb/tb_dispatch.sv

//--- Makefile
# Verilator build and run of the dispatch stage testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dispatch -f list.f -Mdir obj_dir
	out="$$(./obj_dir/Vtb_dispatch)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb/tb_dispatch.sv
// random dispatch test against a shadow slot table; rd and free use x0..x7 only and the simulator must support concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module tb_dispatch import dispatch_pkg::*;;

	localparam int SLOTS        = `RN_SLOTS;
	localparam int SLOT_W       = `RN_SLOT_W;
	localparam int N_INSTR      = 2000;
	localparam int RESET_CYCLES = 8;
	// four cycles per instruction covers the expected 1.5 plus run-out stalls
	localparam int MAX_CYCLES   = 4 * N_INSTR + RESET_CYCLES;

	logic                  clk;
	logic                  rst;
	logic                  instr_valid;
	logic                  instr_ready;
	logic [31:0]           instr;
	logic [`XLEN-1:0]      pc;
	logic                  alu_valid, br_valid, mem_valid, rob_valid;
	logic                  alu_ready, br_ready, mem_ready, rob_ready;
	logic [5:0]            uop_op;
	logic [`XLEN-1:0]      uop_imm, uop_pc, rob_pc;
	logic [`RN_TAG_W-1:0]  rd_tag, rs1_tag, rs2_tag, rob_rd_tag;
	logic                  rob_has_rd;
	logic [1:0]            rob_class;
	logic                  free_valid;
	logic [4:0]            free_reg;
	logic [SLOT_W-1:0]     free_slot;

	// shadow copy of the rename state
	logic [SLOTS-1:0]      sh_busy [0:31];
	logic [SLOT_W-1:0]     sh_cur  [0:31];

	op_class_e             exp_cls;
	uop_op_e               exp_op;
	logic                  exp_needs_rd, exp_runout, exp_ready, exp_fire;
	int                    exp_slot;
	logic [3:0]            exp_push;
	logic [`XLEN-1:0]      exp_imm;
	logic [`RN_TAG_W-1:0]  exp_rd_tag, exp_rs1_tag, exp_rs2_tag;

	integer                seed;
	int                    errors, cycles, n_acc, n_drop, n_runout, n_bp;
	logic                  took, was_stalled;
	logic [`RN_TAG_W-1:0]  prev_rs1, prev_rs2;

	dispatch_top dut0 (.*);

	always #20 clk = ~clk;

	// stimulus only produces legal encodings of the supported opcodes
	function automatic op_class_e class_of(input logic [31:0] w);
		case (w[6:0])
			7'b0110111, 7'b0010111, 7'b0010011, 7'b0110011: return CLS_ALU;
			7'b1101111, 7'b1100111, 7'b1100011:             return CLS_BRANCH;
			7'b0000011, 7'b0100011:                         return CLS_MEM;
			default:                                        return CLS_NONE;
		endcase
	endfunction

	// operation named by the opcode and funct fields of a legal word
	function automatic uop_op_e op_of(input logic [31:0] w);
		logic [2:0] f3;
		f3 = w[14:12];
		case (w[6:0])
			7'b0110111: return OP_LUI;
			7'b0010111: return OP_AUIPC;
			7'b1101111: return OP_JAL;
			7'b1100111: return OP_JALR;
			7'b1100011: begin
				case (f3)
					3'b000:  return OP_BEQ;
					3'b001:  return OP_BNE;
					3'b100:  return OP_BLT;
					3'b101:  return OP_BGE;
					3'b110:  return OP_BLTU;
					default: return OP_BGEU;
				endcase
			end
			7'b0000011: begin
				case (f3)
					3'b000:  return OP_LB;
					3'b001:  return OP_LH;
					3'b010:  return OP_LW;
					3'b011:  return OP_LD;
					3'b100:  return OP_LBU;
					3'b101:  return OP_LHU;
					default: return OP_LWU;
				endcase
			end
			7'b0100011: begin
				case (f3[1:0])
					2'b00:   return OP_SB;
					2'b01:   return OP_SH;
					2'b10:   return OP_SW;
					default: return OP_SD;
				endcase
			end
			7'b0010011, 7'b0110011: begin
				case (f3)
					// bit 30 selects sub only in the register form
					3'b000:  return (w[5] && w[30]) ? OP_SUB : OP_ADD;
					3'b001:  return OP_SLL;
					3'b010:  return OP_SLT;
					3'b011:  return OP_SLTU;
					3'b100:  return OP_XOR;
					3'b101:  return w[30] ? OP_SRA : OP_SRL;
					3'b110:  return OP_OR;
					default: return OP_AND;
				endcase
			end
			default: return OP_NOP;
		endcase
	endfunction

	function automatic logic writes_rd(input logic [31:0] w);
		return class_of(w) != CLS_NONE && w[6:0] != 7'b1100011 && w[6:0] != 7'b0100011;
	endfunction

	function automatic logic reads_rs2(input logic [31:0] w);
		return w[6:0] == 7'b0110011 || w[6:0] == 7'b1100011 || w[6:0] == 7'b0100011;
	endfunction

	function automatic logic is_itype(input logic [31:0] w);
		return w[6:0] == 7'b0010011 || w[6:0] == 7'b1100111 || w[6:0] == 7'b0000011;
	endfunction

	function automatic logic [63:0] i_imm(input logic [31:0] w);
		if (w[6:0] == 7'b0010011 && w[13:12] == 2'b01)
			return {58'd0, w[25:20]};
		return {{52{w[31]}}, w[31:20]};
	endfunction

	// -1 when every slot is taken
	function automatic int lowest_free(input logic [SLOTS-1:0] b);
		int s;
		lowest_free = -1;
		for (s = SLOTS - 1; s >= 0; s--)
			if (!b[s])
				lowest_free = s;
	endfunction

	function automatic logic [`RN_TAG_W-1:0] src_tag(input logic [4:0] r,
		input logic [SLOT_W-1:0] slot);
		return (r == 5'd0) ? '0 : {r, slot};
	endfunction

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
		errors++;
		$display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, got);
	endtask

	task automatic make_instr(output logic [31:0] w);
		logic [31:0] r;
		logic [4:0]  rd, rs1, rs2;
		logic [2:0]  f3;
		int          kind;
		r    = $random(seed);
		kind = $unsigned($random(seed)) % 10;
		rd   = {2'b00, r[2:0]};
		rs1  = {2'b00, r[5:3]};
		rs2  = {2'b00, r[8:6]};
		f3   = r[11:9];
		case (kind)
			0: w = {r[31:12], rd, 7'b0110111};
			1: w = {r[31:12], rd, 7'b0010111};
			2: begin
				if (f3 == 3'b001)
					w = {6'b000000, r[25:20], rs1, f3, rd, 7'b0010011};
				else if (f3 == 3'b101)
					w = {r[30] ? 6'b010000 : 6'b000000, r[25:20], rs1, f3, rd, 7'b0010011};
				else
					w = {r[31:20], rs1, f3, rd, 7'b0010011};
			end
			3: w = {(r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000,
				rs2, rs1, f3, rd, 7'b0110011};
			4: w = {r[31:12], rd, 7'b1101111};
			5: w = {r[31:20], rs1, 3'b000, rd, 7'b1100111};
			6: w = {r[31:25], rs2, rs1, f3[2], f3[2] & f3[1], f3[0], r[16:12], 7'b1100011};
			7: w = {r[31:20], rs1, (f3 == 3'b111) ? 3'b110 : f3, rd, 7'b0000011};
			8: w = {r[31:25], rs2, rs1, 1'b0, f3[1:0], r[16:12], 7'b0100011};
			// fence, system, OP-32 and a compressed word
			default: case (r[13:12])
				2'd0:    w = {r[31:7], 7'b0001111};
				2'd1:    w = {r[31:7], 7'b1110011};
				2'd2:    w = {7'd0, rs2, rs1, 3'b000, rd, 7'b0111011};
				default: w = {r[31:2], 2'b01};
			endcase
		endcase
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] w;
		logic [4:0]  fr;
		int          fs;
		int          s;
		r = $random(seed);
		// a stalled instruction stays on the bus unchanged
		if (took || !instr_valid) begin
			make_instr(w);
			instr       = w;
			instr_valid = r[2:0] != 3'd0;
			pc          = pc + 64'd4;
		end
		alu_ready = r[5:3] != 3'd0;
		br_ready  = r[8:6] != 3'd0;
		mem_ready = r[11:9] != 3'd0;
		rob_ready = r[14:12] != 3'd0;
		// lean toward the waiting rd so a run out can clear
		fr = (r[15] && sh_busy[instr[11:7]] != '0) ? instr[11:7] : {2'b00, r[18:16]};
		fs = int'(r[31:24]) % SLOTS;
		if (!sh_busy[fr][fs]) begin
			fs = -1;
			for (s = SLOTS - 1; s >= 0; s--)
				if (sh_busy[fr][s])
					fs = s;
		end
		free_valid = r[21:19] < 3'd4 && fr != 5'd0 && fs >= 0;
		free_reg   = fr;
		free_slot  = SLOT_W'(fs);
	endtask

	always_comb begin
		exp_cls      = class_of(instr);
		exp_op       = op_of(instr);
		exp_needs_rd = writes_rd(instr) && instr[11:7] != 5'd0;
		exp_slot     = lowest_free(sh_busy[instr[11:7]]);
		exp_runout   = exp_needs_rd && exp_slot < 0;
		case (exp_cls)
			CLS_ALU:    exp_ready = alu_ready && rob_ready && !exp_runout;
			CLS_BRANCH: exp_ready = br_ready && rob_ready && !exp_runout;
			CLS_MEM:    exp_ready = mem_ready && rob_ready && !exp_runout;
			default:    exp_ready = 1'b1;
		endcase
		exp_fire = instr_valid && exp_ready && exp_cls != CLS_NONE;
		exp_push = 4'd0;
		if (exp_fire)
			exp_push = {exp_cls == CLS_ALU, exp_cls == CLS_BRANCH, exp_cls == CLS_MEM, 1'b1};
		exp_imm     = i_imm(instr);
		exp_rd_tag  = exp_needs_rd ? {instr[11:7], SLOT_W'(exp_slot)} : '0;
		exp_rs1_tag = src_tag(instr[19:15], sh_cur[instr[19:15]]);
		exp_rs2_tag = reads_rs2(instr) ? src_tag(instr[24:20], sh_cur[instr[24:20]]) : '0;
	end

	always @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < 32; r++) begin
				sh_busy[r] <= '0;
				sh_cur[r]  <= '0;
			end
		end else begin
			if (free_valid)
				sh_busy[free_reg][free_slot] <= 1'b0;
			if (exp_fire && exp_needs_rd) begin
				sh_busy[instr[11:7]][exp_slot] <= 1'b1;
				sh_cur[instr[11:7]]            <= SLOT_W'(exp_slot);
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			{cycles, n_acc, n_drop, n_runout, n_bp} <= '0;
			took        <= 1'b0;
			was_stalled <= 1'b0;
		end else begin
			cycles      <= cycles + 1;
			took        <= instr_valid && instr_ready;
			was_stalled <= instr_valid && !instr_ready;
			prev_rs1    <= rs1_tag;
			prev_rs2    <= rs2_tag;
			n_acc       <= n_acc + (instr_valid && instr_ready);
			n_drop      <= n_drop + (instr_valid && exp_cls == CLS_NONE);
			n_runout    <= n_runout + (instr_valid && exp_runout);
			n_bp        <= n_bp + (instr_valid && !exp_ready && !exp_runout);
		end
	end

	a_ready: assert property (@(posedge clk) disable iff (rst) instr_ready == exp_ready)
		else value_error("instr_ready", $sampled(exp_ready), $sampled(instr_ready));

	a_push: assert property (@(posedge clk) disable iff (rst)
		{alu_valid, br_valid, mem_valid, rob_valid} == exp_push)
		else value_error("alu/br/mem/rob_valid", $sampled(exp_push),
			$sampled({alu_valid, br_valid, mem_valid, rob_valid}));

	a_op: assert property (@(posedge clk) disable iff (rst) instr_valid |-> uop_op == exp_op)
		else value_error("uop_op", $sampled(exp_op), $sampled(uop_op));

	a_imm: assert property (@(posedge clk) disable iff (rst)
		exp_fire && is_itype(instr) |-> uop_imm == exp_imm)
		else value_error("uop_imm", $sampled(exp_imm), $sampled(uop_imm));

	a_pc: assert property (@(posedge clk) disable iff (rst) exp_fire |-> uop_pc == pc)
		else value_error("uop_pc", $sampled(pc), $sampled(uop_pc));

	a_rob_pc: assert property (@(posedge clk) disable iff (rst) exp_fire |-> rob_pc == pc)
		else value_error("rob_pc", $sampled(pc), $sampled(rob_pc));

	a_rd_tag: assert property (@(posedge clk) disable iff (rst)
		exp_fire |-> rd_tag == exp_rd_tag && rob_rd_tag == exp_rd_tag)
		else value_error("rd_tag", $sampled(exp_rd_tag), $sampled(rd_tag));

	a_has_rd: assert property (@(posedge clk) disable iff (rst)
		exp_fire |-> rob_has_rd == exp_needs_rd && rob_class == exp_cls)
		else value_error("rob_has_rd/rob_class", $sampled({exp_needs_rd, exp_cls}),
			$sampled({rob_has_rd, rob_class}));

	a_rs1: assert property (@(posedge clk) disable iff (rst) exp_fire |-> rs1_tag == exp_rs1_tag)
		else value_error("rs1_tag", $sampled(exp_rs1_tag), $sampled(rs1_tag));

	a_rs2: assert property (@(posedge clk) disable iff (rst) exp_fire |-> rs2_tag == exp_rs2_tag)
		else value_error("rs2_tag", $sampled(exp_rs2_tag), $sampled(rs2_tag));

	// a waiting instruction keeps its source tags
	a_held: assert property (@(posedge clk) disable iff (rst)
		was_stalled |-> rs1_tag == prev_rs1 && rs2_tag == prev_rs2)
		else value_error("rs1_tag/rs2_tag held", $sampled({prev_rs1, prev_rs2}),
			$sampled({rs1_tag, rs2_tag}));

	initial begin
		seed        = 32'h9c1c;
		errors      = 0;
		clk         = 1'b0;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = 64'h1000;
		{alu_ready, br_ready, mem_ready, rob_ready} = '0;
		free_valid  = 1'b0;
		free_reg    = '0;
		free_slot   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (n_acc < N_INSTR && cycles < MAX_CYCLES) begin
			drive_inputs();
			@(negedge clk);
		end
		if (cycles >= MAX_CYCLES) begin
			errors++;
			$display("timeout: %0d of %0d instructions accepted in %0d cycles",
				n_acc, N_INSTR, cycles);
		end
		if (n_runout == 0 || n_bp == 0 || n_drop == 0) begin
			errors++;
			$display("stimulus missed a case: run-out, back-pressure or dropped instruction");
		end
		$display("summary: %0d accepted, %0d dropped, %0d run-out, %0d stalled, %0d errors",
			n_acc, n_drop, n_runout, n_bp, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/dispatch_top.sv
// dispatch stage top; zero latency from instruction to pushes, rename state changes only at clk
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module dispatch_top (
	input  logic                  clk,
	input  logic                  rst,

	// instruction in
	input  logic                  instr_valid,
	output logic                  instr_ready,
	input  logic [31:0]           instr,
	input  logic [`XLEN-1:0]      pc,

	// issue queues, shared payload
	output logic                  alu_valid,
	input  logic                  alu_ready,
	output logic                  br_valid,
	input  logic                  br_ready,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output logic [5:0]            uop_op,
	output logic [`XLEN-1:0]      uop_imm,
	output logic [`XLEN-1:0]      uop_pc,
	output logic [`RN_TAG_W-1:0]  rd_tag,
	output logic [`RN_TAG_W-1:0]  rs1_tag,
	output logic [`RN_TAG_W-1:0]  rs2_tag,

	// reorder buffer
	output logic                  rob_valid,
	input  logic                  rob_ready,
	output logic [`XLEN-1:0]      rob_pc,
	output logic [`RN_TAG_W-1:0]  rob_rd_tag,
	output logic                  rob_has_rd,
	output logic [1:0]            rob_class,

	// slot release from commit, always accepted
	input  logic                  free_valid,
	input  logic [4:0]            free_reg,
	input  logic [`RN_SLOT_W-1:0] free_slot
);

	op_class_if cls_if ();
	rename_if   rn_if ();

	op_classify i_classify (
		.instr (instr),
		.cls   (cls_if.src)
	);

	reg_rename i_rename (
		.clk        (clk),
		.rst        (rst),
		.cls        (cls_if.rn_side),
		.rn         (rn_if.rn),
		.free_valid (free_valid),
		.free_reg   (free_reg),
		.free_slot  (free_slot)
	);

	dispatch_steer i_steer (
		.cls         (cls_if.sink),
		.rn          (rn_if.steer),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.pc          (pc),
		.alu_valid   (alu_valid),
		.alu_ready   (alu_ready),
		.br_valid    (br_valid),
		.br_ready    (br_ready),
		.mem_valid   (mem_valid),
		.mem_ready   (mem_ready),
		.uop_op      (uop_op),
		.uop_imm     (uop_imm),
		.uop_pc      (uop_pc),
		.rd_tag      (rd_tag),
		.rs1_tag     (rs1_tag),
		.rs2_tag     (rs2_tag),
		.rob_valid   (rob_valid),
		.rob_ready   (rob_ready),
		.rob_pc      (rob_pc),
		.rob_rd_tag  (rob_rd_tag),
		.rob_has_rd  (rob_has_rd),
		.rob_class   (rob_class)
	);

endmodule

`default_nettype wire

//--- verilog/dispatch_steer.sv
// dispatch handshake logic; all outputs are combinational and instr_ready never depends on instr_valid
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module dispatch_steer import dispatch_pkg::*; (
	op_class_if.sink         cls,
	rename_if.steer          rn,

	input  logic             instr_valid,
	output logic             instr_ready,
	input  logic [`XLEN-1:0] pc,

	output logic             alu_valid,
	input  logic             alu_ready,
	output logic             br_valid,
	input  logic             br_ready,
	output logic             mem_valid,
	input  logic             mem_ready,

	output uop_op_e          uop_op,
	output logic [`XLEN-1:0] uop_imm,
	output logic [`XLEN-1:0] uop_pc,
	output rn_tag_t          rd_tag,
	output rn_tag_t          rs1_tag,
	output rn_tag_t          rs2_tag,

	output logic             rob_valid,
	input  logic             rob_ready,
	output logic [`XLEN-1:0] rob_pc,
	output rn_tag_t          rob_rd_tag,
	output logic             rob_has_rd,
	output op_class_e        rob_class
);

	logic supported;
	logic tgt_ready;
	logic can_go;
	logic fire;

	assign supported = (cls.cls != CLS_NONE);

	always_comb begin
		case (cls.cls)
			CLS_ALU:    tgt_ready = alu_ready;
			CLS_BRANCH: tgt_ready = br_ready;
			CLS_MEM:    tgt_ready = mem_ready;
			default:    tgt_ready = 1'b0;
		endcase
	end

	// room in the queue and the rob, and a slot for rd when one is needed
	assign can_go = tgt_ready && rob_ready && !(cls.needs_rd && rn.run_out);

	// unsupported words are simply consumed
	assign instr_ready = !supported || can_go;
	assign fire        = instr_valid && supported && can_go;

	assign alu_valid = fire && (cls.cls == CLS_ALU);
	assign br_valid  = fire && (cls.cls == CLS_BRANCH);
	assign mem_valid = fire && (cls.cls == CLS_MEM);
	assign rob_valid = fire;

	assign rn.alloc = fire && cls.needs_rd;

	assign uop_op  = cls.op;
	assign uop_imm = cls.imm;
	assign uop_pc  = pc;
	assign rd_tag  = cls.needs_rd ? rn.rd_tag : '0;
	assign rs1_tag = rn.rs1_tag;
	assign rs2_tag = rn.rs2_tag;

	assign rob_pc     = pc;
	assign rob_rd_tag = rd_tag;
	assign rob_has_rd = cls.needs_rd;
	assign rob_class  = cls.cls;

endmodule

`default_nettype wire

//--- verilog/reg_rename.sv
// slot rename table; x0 never owns slots, and a free must name a slot that is currently busy
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

module reg_rename import dispatch_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	op_class_if.rn_side           cls,
	rename_if.rn                  rn,
	input  logic                  free_valid,
	input  logic [4:0]            free_reg,
	input  logic [`RN_SLOT_W-1:0] free_slot
);

	localparam int SLOTS  = `RN_SLOTS;
	localparam int SLOT_W = `RN_SLOT_W;

	// x0 has no entry
	logic [SLOTS-1:0]  busy [1:`ARCH_REGS-1];
	logic [SLOT_W-1:0] cur  [1:`ARCH_REGS-1];

	logic [SLOTS-1:0]  rd_busy;
	logic [SLOT_W-1:0] alloc_slot;
	logic              free_hit;

	// busy view of rd; x0 looks all free so it never runs out
	always_comb begin
		rd_busy = '0;
		if (cls.rd != 5'd0)
			rd_busy = busy[cls.rd];
	end

	// lowest free slot wins
	always_comb begin
		alloc_slot = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (!rd_busy[s])
				alloc_slot = SLOT_W'(s);
		end
	end

	assign rn.run_out = (cls.rd != 5'd0) && (&rd_busy);
	assign rn.rd_tag  = '{areg: cls.rd, slot: alloc_slot};

	// sources see the last committed allocation
	always_comb begin
		rn.rs1_tag = '0;
		rn.rs2_tag = '0;
		if (cls.rs1 != 5'd0)
			rn.rs1_tag = '{areg: cls.rs1, slot: cur[cls.rs1]};
		if (cls.rs2 != 5'd0)
			rn.rs2_tag = '{areg: cls.rs2, slot: cur[cls.rs2]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 1; r < `ARCH_REGS; r++) begin
				busy[r] <= '0;
				cur[r]  <= '0;
			end
		end else begin
			// a free names a busy slot and alloc a free one so the two never meet
			if (free_valid && free_reg != 5'd0)
				busy[free_reg][free_slot] <= 1'b0;
			if (rn.alloc && cls.rd != 5'd0) begin
				busy[cls.rd][alloc_slot] <= 1'b1;
				cur[cls.rd]              <= alloc_slot;
			end
		end
	end

	always_comb begin
		free_hit = 1'b0;
		if (free_reg != 5'd0)
			free_hit = busy[free_reg][free_slot];
	end

	// steer must hold off a full register
	a_no_alloc_on_run_out: assert property (@(posedge clk) disable iff (rst)
		rn.alloc |-> !rn.run_out)
		else $error("rename: alloc while run_out, rd=%0d", cls.rd);

	// commit only returns slots it was given earlier
	a_free_is_busy: assert property (@(posedge clk) disable iff (rst)
		free_valid |-> free_hit)
		else $error("rename: free of idle slot %0d.%0d", free_reg, free_slot);

endmodule

`default_nettype wire

//--- verilog/op_classify.sv
// pure combinational RV64I decode; fence, system, csr, compressed and W forms come out as CLS_NONE
`timescale 1ns/1ps
`default_nettype none

module op_classify import dispatch_pkg::*; (
	input logic [31:0] instr,
	op_class_if.src    cls
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	imm12_u     i12;

	op_class_e        dec_cls;
	uop_op_e          dec_op;
	logic [`XLEN-1:0] dec_imm;
	logic             reads_rs2;
	logic             writes_rd;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign i12    = instr[31:20];

	always_comb begin
		dec_cls   = CLS_NONE;
		dec_op    = OP_NOP;
		dec_imm   = '0;
		reads_rs2 = 1'b0;
		writes_rd = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				dec_cls   = CLS_ALU;
				dec_op    = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
				dec_imm   = {{32{instr[31]}}, instr[31:12], 12'd0};
				writes_rd = 1'b1;
			end
			OPC_JAL: begin
				dec_cls   = CLS_BRANCH;
				dec_op    = OP_JAL;
				dec_imm   = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
				writes_rd = 1'b1;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					dec_cls   = CLS_BRANCH;
					dec_op    = OP_JALR;
					dec_imm   = {{52{i12.simm[11]}}, i12.simm};
					writes_rd = 1'b1;
				end
			end
			OPC_BRANCH: begin
				// funct3 010 and 011 are not branches
				if (funct3[2:1] != 2'b01) begin
					dec_cls   = CLS_BRANCH;
					dec_op    = uop_op_e'(OP_BEQ + (funct3[2] ? funct3 - 3'd2 : funct3));
					dec_imm   = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
						instr[11:8], 1'b0};
					reads_rs2 = 1'b1;
				end
			end
			OPC_LOAD: begin
				if (funct3 != 3'b111) begin
					dec_cls   = CLS_MEM;
					dec_op    = uop_op_e'(OP_LB + funct3);
					dec_imm   = {{52{i12.simm[11]}}, i12.simm};
					writes_rd = 1'b1;
				end
			end
			OPC_STORE: begin
				if (!funct3[2]) begin
					dec_cls   = CLS_MEM;
					dec_op    = uop_op_e'(OP_SB + funct3);
					dec_imm   = {{52{instr[31]}}, instr[31:25], instr[11:7]};
					reads_rs2 = 1'b1;
				end
			end
			OPC_OPIMM: begin
				dec_imm   = {{52{i12.simm[11]}}, i12.simm};
				writes_rd = 1'b1;
				dec_cls   = CLS_ALU;
				case (funct3)
					3'b000: dec_op = OP_ADD;
					3'b010: dec_op = OP_SLT;
					3'b011: dec_op = OP_SLTU;
					3'b100: dec_op = OP_XOR;
					3'b110: dec_op = OP_OR;
					3'b111: dec_op = OP_AND;
					default: begin
						// shifts take a zero extended 6-bit shamt
						dec_imm = {58'd0, i12.shift.shamt};
						if (funct3 == 3'b001 && i12.shift.funct6 == 6'b000000)
							dec_op = OP_SLL;
						else if (i12.shift.funct6 == 6'b000000)
							dec_op = OP_SRL;
						else if (i12.shift.funct6 == 6'b010000 && funct3 == 3'b101)
							dec_op = OP_SRA;
						else
							dec_cls = CLS_NONE;
					end
				endcase
			end
			OPC_OP: begin
				writes_rd = 1'b1;
				reads_rs2 = 1'b1;
				dec_cls   = CLS_ALU;
				case ({funct7, funct3})
					10'b0000000_000: dec_op = OP_ADD;
					10'b0100000_000: dec_op = OP_SUB;
					10'b0000000_001: dec_op = OP_SLL;
					10'b0000000_010: dec_op = OP_SLT;
					10'b0000000_011: dec_op = OP_SLTU;
					10'b0000000_100: dec_op = OP_XOR;
					10'b0000000_101: dec_op = OP_SRL;
					10'b0100000_101: dec_op = OP_SRA;
					10'b0000000_110: dec_op = OP_OR;
					10'b0000000_111: dec_op = OP_AND;
					default:         dec_cls = CLS_NONE;
				endcase
			end
			default: dec_cls = CLS_NONE;
		endcase
	end

	assign cls.cls      = dec_cls;
	assign cls.op       = dec_op;
	assign cls.imm      = dec_imm;
	assign cls.rd       = instr[11:7];
	assign cls.rs1      = instr[19:15];
	assign cls.rs2      = reads_rs2 ? instr[24:20] : 5'd0;
	assign cls.needs_rd = writes_rd && (dec_cls != CLS_NONE) && (instr[11:7] != 5'd0);

endmodule

`default_nettype wire

//--- verilog/dispatch_ifs.sv
// internal dispatch interfaces; op_class_if is combinational decode output, rename_if mixes directions
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_macros.svh"

interface op_class_if import dispatch_pkg::*;;
	op_class_e        cls;
	uop_op_e          op;
	logic [`XLEN-1:0] imm;
	logic [4:0]       rd;
	logic [4:0]       rs1;
	logic [4:0]       rs2;
	// rd is written and is not x0
	logic             needs_rd;

	modport src     (output cls, op, imm, rd, rs1, rs2, needs_rd);
	modport rn_side (input rd, rs1, rs2);
	modport sink    (input cls, op, imm, needs_rd);
endinterface

interface rename_if import dispatch_pkg::*;;
	rn_tag_t rs1_tag;
	rn_tag_t rs2_tag;
	// lowest free slot of rd, offered before the edge
	rn_tag_t rd_tag;
	logic    run_out;
	logic    alloc;

	modport rn    (output rs1_tag, rs2_tag, rd_tag, run_out, input alloc);
	modport steer (input rs1_tag, rs2_tag, rd_tag, run_out, output alloc);
endinterface

`default_nettype wire

//--- verilog/dispatch_pkg.sv
// dispatch types; the tag layout follows RN_SLOT_W, so include the macros header before this package
`default_nettype none

`include "dispatch_macros.svh"

package dispatch_pkg;

	// target issue queue of a micro-op
	typedef enum logic [1:0] {
		CLS_ALU    = 2'd0,
		CLS_BRANCH = 2'd1,
		CLS_MEM    = 2'd2,
		CLS_NONE   = 2'd3
	} op_class_e;

	// concrete operation, OP_NOP only for dropped instructions
	typedef enum logic [5:0] {
		OP_NOP,
		OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
		OP_SLL, OP_SRL, OP_SRA,
		OP_LUI, OP_AUIPC,
		OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
		OP_SB, OP_SH, OP_SW, OP_SD
	} uop_op_e;

	// shift view of instr[31:20]
	typedef struct packed {
		logic [5:0] funct6;
		logic [5:0] shamt;
	} shift_fld_t;

	// instr[31:20] read as a signed immediate or as funct6/shamt
	typedef union packed {
		logic signed [11:0] simm;
		shift_fld_t         shift;
	} imm12_u;

	// tag zero is reserved for x0
	typedef struct packed {
		logic [4:0]            areg;
		logic [`RN_SLOT_W-1:0] slot;
	} rn_tag_t;

endpackage

`default_nettype wire

//--- verilog/dispatch_macros.svh
// rename sizing; RN_SLOTS must be a power of two (2, 4 or 8 are the intended values)
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// rename slots kept per architectural register
`define RN_SLOTS 4

// width of one slot index
`define RN_SLOT_W $clog2(`RN_SLOTS)

// renamed tag is the architectural register joined to its slot
`define RN_TAG_W (5 + `RN_SLOT_W)

// architectural register file size
`define ARCH_REGS 32

// datapath width of pc and immediates
`define XLEN 64

`endif
